// File: Makefile
# Verilator build and run for the memory system testbench

VERILATOR ?= verilator
TOP       ?= memSystemTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
logic/memSysPkg.sv
logic/busPkg.sv
logic/cacheControl.sv
logic/instrCache.sv
logic/dataCache.sv
logic/busArbiter.sv
logic/mainMemory.sv
logic/memSystem.sv
testbench/memSystemTb.sv

// File: logic/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
  input  wire                  clk,
  input  wire                  rst,
  input  wire busPkg::busReq_t iReq,
  input  wire busPkg::busReq_t dReq,
  output busPkg::busReq_t      mem,
  input  wire busPkg::busRsp_t memRsp,
  output busPkg::busRsp_t      iRsp,
  output busPkg::busRsp_t      dRsp
);

  // Last cycle's owner, high for the data side
  logic ownerD;
  // Owner still has a transfer open
  logic ownerBusy;
  // Grant for this cycle
  logic grantD;

  assign ownerBusy = ownerD ? dReq.request : iReq.request;

  // Owner keeps the bus, else data first
  assign grantD = ownerBusy ? ownerD : dReq.request;

  always_ff @(posedge clk) begin
    if (rst) begin
      ownerD <= 1'b0;
    end else begin
      ownerD <= grantD;
    end
  end

  assign mem = grantD ? dReq : iReq;

  // Loser never sees ready
  always_comb begin
    iRsp       = memRsp;
    dRsp       = memRsp;
    iRsp.ready = memRsp.ready && !grantD;
    dRsp.ready = memRsp.ready && grantD;
  end

endmodule

`default_nettype wire

// File: logic/busPkg.sv
`default_nettype none

package busPkg;

  // Master side of one word transfer
  // Held stable by the master until ready
  typedef struct packed {
    logic        request;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  byteMask;
  } busReq_t;

  // Slave side, ready high one cycle per word
  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } busRsp_t;

endpackage

`default_nettype wire

// File: logic/cacheControl.sv
`timescale 1ns/1ps
`default_nettype none

module cacheControl (
  input  wire                clk,
  input  wire                rst,
  input  wire memSysPkg::cpReq_t cp,
  output logic [31:0]        cpRdata,
  output logic               enI,
  output logic               enD,
  output logic               invI,
  output logic               invD
);

  // Control register, register 1
  logic [31:0] ctrlReg;
  // Register 7 cache operation with op2 of zero
  logic        cacheOp;

  assign cacheOp = cp.write && (cp.regNum == 4'd7) && (cp.op2 == 3'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlReg <= '0;
      invI    <= 1'b0;
      invD    <= 1'b0;
    end else begin
      // Only register 1 is writable
      if (cp.write && (cp.regNum == 4'd1)) begin
        ctrlReg <= cp.wdata;
      end
      // crm 5 instr, crm 6 data, crm 7 both
      invI <= cacheOp && ((cp.crm == 4'd5) || (cp.crm == 4'd7));
      invD <= cacheOp && ((cp.crm == 4'd6) || (cp.crm == 4'd7));
    end
  end

  // Enables straight from control bits
  assign enI = ctrlReg[memSysPkg::CTRL_I_BIT];
  assign enD = ctrlReg[memSysPkg::CTRL_D_BIT];

  // Readback from registered state only
  always_comb begin
    cpRdata = '0;
    if (cp.read) begin
      case (cp.regNum)
        4'd0:    cpRdata = memSysPkg::CP_ID_VALUE;
        4'd1:    cpRdata = ctrlReg;
        default: cpRdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/dataCache.sv
`timescale 1ns/1ps
`default_nettype none

module dataCache #(
  parameter int Lines      = 64,
  parameter int BlockWords = 4
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  en,
  input  wire                  inv,
  input  wire memSysPkg::dataReq_t data,
  output logic [31:0]          rdata,
  output logic                 dStall,
  output busPkg::busReq_t      busOut,
  input  wire busPkg::busRsp_t busIn
);

  localparam int WordBits  = $clog2(BlockWords);
  localparam int IndexBits = $clog2(Lines);
  localparam int LineLsb   = 2 + WordBits;
  localparam int TagBits   = 32 - LineLsb - IndexBits;

  typedef enum logic [1:0] {Idle, Fill, Uncached, WriteThru} state_t;

  state_t              state;
  logic [WordBits-1:0] wordCnt;
  logic                invPending;

  // Line storage
  logic [Lines-1:0]    valid;
  logic [TagBits-1:0]  tagArr [Lines];
  logic [31:0]         dataArr [Lines][BlockWords];

  // Access address split
  logic [TagBits-1:0]   tag;
  logic [IndexBits-1:0] idx;
  logic [WordBits-1:0]  wordSel;
  logic                 flushNow;
  logic                 lineHit;
  logic                 hit;
  logic                 lastWord;
  logic                 done;

  assign tag     = data.adr[31 -: TagBits];
  assign idx     = data.adr[LineLsb +: IndexBits];
  assign wordSel = data.adr[2 +: WordBits];

  // Invalidate only lands while idle
  assign flushNow = (inv || invPending) && (state == Idle);
  // Resident line, used for store patching even when disabled
  assign lineHit  = valid[idx] && (tagArr[idx] == tag);
  assign hit      = en && lineHit && !flushNow;
  assign lastWord = wordCnt == WordBits'(BlockWords - 1);

  // Read hit now, single words on their ready
  assign done = ((state == Idle) && data.read && !data.write && hit) ||
                (((state == Uncached) || (state == WriteThru)) && busIn.ready);

  assign dStall = (data.read || data.write) && !done;
  assign rdata  = (state == Uncached) ? busIn.rdata : dataArr[idx][wordSel];

  // Stores go through with the core byte mask
  assign busOut.request  = state != Idle;
  assign busOut.write    = state == WriteThru;
  assign busOut.addr     = (state == Fill) ? {data.adr[31:LineLsb], wordCnt, 2'b00}
                                           : {data.adr[31:2], 2'b00};
  assign busOut.wdata    = data.wdata;
  assign busOut.byteMask = (state == WriteThru) ? data.byteMask : 4'hF;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= Idle;
      wordCnt    <= '0;
      invPending <= 1'b0;
      valid      <= '0;
    end else begin
      if (flushNow) begin
        valid      <= '0;
        invPending <= 1'b0;
      end else if (inv) begin
        invPending <= 1'b1;
      end
      case (state)
        Idle: begin
          if (data.write) begin
            state <= WriteThru;
          end else if (data.read && !hit) begin
            wordCnt <= '0;
            state   <= en ? Fill : Uncached;
          end
        end
        Fill: begin
          if (busIn.ready) begin
            wordCnt <= wordCnt + 1'b1;
            if (lastWord) begin
              valid[idx] <= 1'b1;
              state      <= Idle;
            end
          end
        end
        // Back to idle once the word is done
        Uncached, WriteThru: begin
          if (busIn.ready) begin
            state <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // Line fill
    if ((state == Fill) && busIn.ready) begin
      dataArr[idx][wordCnt] <= busIn.rdata;
      if (lastWord) begin
        tagArr[idx] <= tag;
      end
    end
    // No allocate on write, patch only a resident line
    if ((state == WriteThru) && busIn.ready && lineHit) begin
      for (int b = 0; b < 4; b++) begin
        if (data.byteMask[b]) begin
          dataArr[idx][wordSel][8*b +: 8] <= data.wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/instrCache.sv
`timescale 1ns/1ps
`default_nettype none

module instrCache #(
  parameter int Lines      = 64,
  parameter int BlockWords = 4
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   en,
  input  wire                   inv,
  input  wire memSysPkg::fetchReq_t fetch,
  output logic [31:0]           instr,
  output logic                  iStall,
  output busPkg::busReq_t       busOut,
  input  wire busPkg::busRsp_t  busIn
);

  localparam int WordBits  = $clog2(BlockWords);
  localparam int IndexBits = $clog2(Lines);
  localparam int LineLsb   = 2 + WordBits;
  localparam int TagBits   = 32 - LineLsb - IndexBits;

  typedef enum logic [1:0] {Idle, Fill, Uncached} state_t;

  state_t              state;
  logic [WordBits-1:0] wordCnt;
  logic                invPending;

  // Line storage
  logic [Lines-1:0]    valid;
  logic [TagBits-1:0]  tagArr [Lines];
  logic [31:0]         dataArr [Lines][BlockWords];

  // Fetch address split
  logic [TagBits-1:0]   tag;
  logic [IndexBits-1:0] idx;
  logic [WordBits-1:0]  wordSel;
  logic                 flushNow;
  logic                 hit;
  logic                 lastWord;

  assign tag     = fetch.pc[31 -: TagBits];
  assign idx     = fetch.pc[LineLsb +: IndexBits];
  assign wordSel = fetch.pc[2 +: WordBits];

  // Invalidate only lands while idle
  assign flushNow = (inv || invPending) && (state == Idle);
  // A line about to be flushed never hits
  assign hit      = en && valid[idx] && (tagArr[idx] == tag) && !flushNow;
  assign lastWord = wordCnt == WordBits'(BlockWords - 1);

  // Uncached word completes in its ready cycle
  assign iStall = fetch.fetch &&
                  !(((state == Idle) && hit) || ((state == Uncached) && busIn.ready));
  assign instr  = (state == Uncached) ? busIn.rdata : dataArr[idx][wordSel];

  // Read-only master
  assign busOut.request  = state != Idle;
  assign busOut.write    = 1'b0;
  assign busOut.addr     = (state == Fill) ? {fetch.pc[31:LineLsb], wordCnt, 2'b00}
                                           : {fetch.pc[31:2], 2'b00};
  assign busOut.wdata    = '0;
  assign busOut.byteMask = 4'hF;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= Idle;
      wordCnt    <= '0;
      invPending <= 1'b0;
      valid      <= '0;
    end else begin
      if (flushNow) begin
        valid      <= '0;
        invPending <= 1'b0;
      end else if (inv) begin
        invPending <= 1'b1;
      end
      case (state)
        Idle: begin
          if (fetch.fetch && !hit) begin
            wordCnt <= '0;
            state   <= en ? Fill : Uncached;
          end
        end
        Fill: begin
          // Next word address in the cycle after ready
          if (busIn.ready) begin
            wordCnt <= wordCnt + 1'b1;
            if (lastWord) begin
              valid[idx] <= 1'b1;
              state      <= Idle;
            end
          end
        end
        Uncached: begin
          if (busIn.ready) begin
            state <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // Fill words and tag
  always_ff @(posedge clk) begin
    if ((state == Fill) && busIn.ready) begin
      dataArr[idx][wordCnt] <= busIn.rdata;
      if (lastWord) begin
        tagArr[idx] <= tag;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/mainMemory.sv
`timescale 1ns/1ps
`default_nettype none

module mainMemory #(
  parameter int MemWords   = 4096,
  parameter int WaitStates = 2
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire busPkg::busReq_t req,
  output busPkg::busRsp_t      rsp
);

  localparam int AdrBits = $clog2(MemWords);
  // Room for a count of zero wait states too
  localparam int CntBits = $clog2(WaitStates + 2);

  logic [31:0]        mem [MemWords];
  logic [CntBits-1:0] waitCnt;
  logic               readyQ;
  logic [31:0]        rdataQ;
  logic [AdrBits-1:0] wordAdr;
  logic               fire;

  // Word index, wraps at the array size
  assign wordAdr = req.addr[2 +: AdrBits];

  // Last wait cycle, ready follows on the next edge
  assign fire = req.request && !readyQ && (waitCnt == CntBits'(WaitStates));

  initial begin
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      waitCnt <= '0;
      readyQ  <= 1'b0;
    end else begin
      readyQ <= fire;
      // Restart count after each ready so the next word waits again
      if (req.request && !readyQ && !fire) begin
        waitCnt <= waitCnt + 1'b1;
      end else begin
        waitCnt <= '0;
      end
    end
  end

  // Data and byte writes visible with ready
  always_ff @(posedge clk) begin
    if (fire) begin
      rdataQ <= mem[wordAdr];
      if (req.write) begin
        for (int b = 0; b < 4; b++) begin
          if (req.byteMask[b]) begin
            mem[wordAdr][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign rsp.ready = readyQ;
  assign rsp.rdata = rdataQ;

endmodule

`default_nettype wire

// File: logic/memSysPkg.sv
`default_nettype none

package memSysPkg;

  // Default cache geometry, overridden through memSystem parameters
  localparam int LINES       = 64;
  localparam int BLOCK_WORDS = 4;

  // Address split widths for the default geometry
  localparam int BYTE_BITS  = 2;
  localparam int WORD_BITS  = $clog2(BLOCK_WORDS);
  localparam int INDEX_BITS = $clog2(LINES);
  localparam int TAG_BITS   = 32 - INDEX_BITS - WORD_BITS - BYTE_BITS;

  // Cache enable bits in the control register
  localparam int CTRL_I_BIT = 12;
  localparam int CTRL_D_BIT = 2;

  // Register 0 identification word
  localparam logic [31:0] CP_ID_VALUE = 32'h0C0A_0001;

  typedef logic [31:0] addr_t;

  // Byte address as seen by a direct-mapped cache
  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] index;
    logic [WORD_BITS-1:0]  word;
    logic [BYTE_BITS-1:0]  byteOff;
  } addrFields_t;

  // Core load or store
  typedef struct packed {
    logic        read;
    logic        write;
    addr_t       adr;
    logic [31:0] wdata;
    logic [3:0]  byteMask;
  } dataReq_t;

  // Core instruction fetch
  typedef struct packed {
    logic  fetch;
    addr_t pc;
  } fetchReq_t;

  // System-control coprocessor access, MCR or MRC style
  typedef struct packed {
    logic        write;
    logic        read;
    logic [3:0]  regNum;
    logic [3:0]  crm;
    logic [2:0]  op2;
    logic [31:0] wdata;
  } cpReq_t;

endpackage

`default_nettype wire

// File: logic/memSystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSystem #(
  parameter int Lines      = memSysPkg::LINES,
  parameter int BlockWords = memSysPkg::BLOCK_WORDS,
  parameter int MemWords   = 4096,
  parameter int WaitStates = 2
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire memSysPkg::fetchReq_t fetch,
  input  wire memSysPkg::dataReq_t  data,
  input  wire memSysPkg::cpReq_t    cp,
  output logic [31:0]            instr,
  output logic                   iStall,
  output logic [31:0]            rdata,
  output logic                   dStall,
  output logic [31:0]            cpRdata
);

  // Cache enables and invalidate pulses
  logic enI;
  logic enD;
  logic invI;
  logic invD;

  // Bus between masters, arbiter and memory
  busPkg::busReq_t iBusReq;
  busPkg::busReq_t dBusReq;
  busPkg::busReq_t memReq;
  busPkg::busRsp_t iBusRsp;
  busPkg::busRsp_t dBusRsp;
  busPkg::busRsp_t memRsp;

  cacheControl u_cacheControl (
    .clk(clk), .rst(rst), .cp(cp), .cpRdata(cpRdata),
    .enI(enI), .enD(enD), .invI(invI), .invD(invD)
  );

  instrCache #(.Lines(Lines), .BlockWords(BlockWords)) u_instrCache (
    .clk(clk), .rst(rst), .en(enI), .inv(invI), .fetch(fetch),
    .instr(instr), .iStall(iStall), .busOut(iBusReq), .busIn(iBusRsp)
  );

  dataCache #(.Lines(Lines), .BlockWords(BlockWords)) u_dataCache (
    .clk(clk), .rst(rst), .en(enD), .inv(invD), .data(data),
    .rdata(rdata), .dStall(dStall), .busOut(dBusReq), .busIn(dBusRsp)
  );

  busArbiter u_busArbiter (
    .clk(clk), .rst(rst), .iReq(iBusReq), .dReq(dBusReq), .mem(memReq),
    .memRsp(memRsp), .iRsp(iBusRsp), .dRsp(dBusRsp)
  );

  mainMemory #(.MemWords(MemWords), .WaitStates(WaitStates)) u_mainMemory (
    .clk(clk), .rst(rst), .req(memReq), .rsp(memRsp)
  );

endmodule

`default_nettype wire

// File: testbench/memSystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSystemTb;

  localparam int Lines      = memSysPkg::LINES;
  localparam int BlockWords = memSysPkg::BLOCK_WORDS;
  localparam int MemWords   = 4096;
  localparam int WaitStates = 2;
  localparam int IndexBits  = $clog2(Lines);
  localparam int LineLsb    = 2 + $clog2(BlockWords);

  // Stimulus regions
  localparam logic [31:0] DataBase = 32'h0000_0400;
  localparam int          DataWords = 64;
  localparam logic [31:0] CodeBase = 32'h0000_2000;
  localparam int          CodeWords = 128;
  // Wider than the icache so lines get evicted
  localparam int          MixWords = 1024;

  // Loop lengths per test
  localparam int NumBasic = 40;
  localparam int NumData  = 60;
  localparam int NumCode  = 40;
  localparam int NumMixed = 40;
  localparam int TotalAccesses = 4 * NumBasic + 2 * NumData + NumCode + 2 * NumMixed + 32;
  // Room for a full line fill queued behind the other side's fill
  localparam int CycleLimit = 200 + TotalAccesses * 4 * (BlockWords + WaitStates + 2);

  logic                 clk;
  logic                 rst;
  memSysPkg::fetchReq_t fetch;
  memSysPkg::dataReq_t  data;
  memSysPkg::cpReq_t    cp;
  logic [31:0]          instr;
  logic                 iStall;
  logic [31:0]          rdata;
  logic                 dStall;
  logic [31:0]          cpRdata;

  // Memory model and icache mirror
  logic [31:0]      model [MemWords];
  logic [Lines-1:0] mirValid;
  logic [31:0]      mirTag [Lines];
  logic [31:0]      mirData [Lines][BlockWords];

  logic [31:0] stalePc;
  logic [31:0] mixPc [NumMixed];
  logic [31:0] mixAdr [NumMixed];
  int          errorCount = 0;
  int          cycleCount = 0;

  memSystem #(
    .Lines(Lines), .BlockWords(BlockWords), .MemWords(MemWords), .WaitStates(WaitStates)
  ) u_memSystem (
    .clk(clk), .rst(rst), .fetch(fetch), .data(data), .cp(cp),
    .instr(instr), .iStall(iStall), .rdata(rdata), .dStall(dStall), .cpRdata(cpRdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // Watchdog
  always @(posedge clk) begin
    if (cycleCount == CycleLimit) begin
      stopRun($sformatf("Timeout after %0d cycles, an access never completed", cycleCount));
    end else begin
      cycleCount++;
    end
  end

  task automatic stopRun(input string why);
    errorCount++;
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else stopRun($sformatf("Fail %s expected %h actual %h", name, exp, act));
  endtask

  // Memory wraps modulo its size
  function automatic int unsigned wordIndex(input logic [31:0] adr);
    return (adr >> 2) % MemWords;
  endfunction

  function automatic logic [31:0] randomWordAddr(input logic [31:0] base,
                                                 input int unsigned words);
    return base + 32'(4 * ($urandom % words));
  endfunction

  // Byte-masked write into the model
  task automatic modelStore(input logic [31:0] adr, input logic [31:0] wd,
                            input logic [3:0] mask);
    int unsigned w;
    w = wordIndex(adr);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        model[w][8*b +: 8] = wd[8*b +: 8];
      end
    end
  endtask

  // Predicted icache word with mirror fill on a miss
  task automatic mirrorLookup(input logic [31:0] pc, output logic [31:0] word);
    int unsigned idx;
    logic [31:0] tag;
    logic [31:0] base;
    idx  = (pc >> LineLsb) % Lines;
    tag  = pc >> (LineLsb + IndexBits);
    base = (pc >> LineLsb) << LineLsb;
    if (!(mirValid[idx] && (mirTag[idx] == tag))) begin
      for (int k = 0; k < BlockWords; k++) begin
        mirData[idx][k] = model[wordIndex(base + 32'(4 * k))];
      end
      mirTag[idx]   = tag;
      mirValid[idx] = 1'b1;
    end
    word = mirData[idx][(pc >> 2) % BlockWords];
  endtask

  // Starts on a falling edge and drops the request on a later one
  task automatic doFetch(input logic [31:0] pc, output logic [31:0] word,
                         output logic stalledFirst);
    fetch.fetch = 1'b1;
    fetch.pc    = pc;
    #1;
    stalledFirst = iStall;
    while (iStall) begin
      @(negedge clk);
      #1;
    end
    word = instr;
    @(negedge clk);
    fetch.fetch = 1'b0;
  endtask

  task automatic dataAccess(input logic rd, input logic wr, input logic [31:0] adr,
                            input logic [31:0] wd, input logic [3:0] mask,
                            output logic [31:0] word, output logic stalledFirst);
    data.read     = rd;
    data.write    = wr;
    data.adr      = adr;
    data.wdata    = wd;
    data.byteMask = mask;
    #1;
    stalledFirst = dStall;
    // Held until the stall drops
    while (dStall) begin
      @(negedge clk);
      #1;
    end
    word = rdata;
    @(negedge clk);
    data.read  = 1'b0;
    data.write = 1'b0;
  endtask

  task automatic loadWord(input logic [31:0] adr, output logic [31:0] word,
                          output logic stalledFirst);
    dataAccess(1'b1, 1'b0, adr, 32'h0, 4'h0, word, stalledFirst);
  endtask

  task automatic storeWord(input logic [31:0] adr, input logic [31:0] wd,
                           input logic [3:0] mask);
    logic [31:0] unusedWord;
    logic        unusedStall;
    dataAccess(1'b0, 1'b1, adr, wd, mask, unusedWord, unusedStall);
    modelStore(adr, wd, mask);
  endtask

  task automatic cpWrite(input logic [3:0] regNum, input logic [3:0] crm,
                         input logic [31:0] wd);
    cp.write  = 1'b1;
    cp.regNum = regNum;
    cp.crm    = crm;
    cp.op2    = 3'd0;
    cp.wdata  = wd;
    @(negedge clk);
    cp.write = 1'b0;
  endtask

  task automatic cpRead(input logic [3:0] regNum, output logic [31:0] value);
    cp.read   = 1'b1;
    cp.regNum = regNum;
    #1;
    value = cpRdata;
    @(negedge clk);
    cp.read = 1'b0;
  endtask

  // Both caches off so every access is a single bus word
  task automatic uncachedAccesses();
    logic [31:0] adr;
    logic [31:0] got;
    logic        st;
    cpRead(4'd1, got);
    checkWord("ctrlAfterReset", 32'h0, got);
    for (int i = 0; i < NumBasic; i++) begin
      adr = randomWordAddr(32'h0, MemWords);
      storeWord(adr, $urandom, 4'($urandom));
      loadWord(adr, got, st);
      checkWord("uncachedLoadBack", model[wordIndex(adr)], got);
      adr = randomWordAddr(32'h0, MemWords);
      loadWord(adr, got, st);
      checkWord("uncachedLoad", model[wordIndex(adr)], got);
      doFetch(adr, got, st);
      checkWord("uncachedFetch", model[wordIndex(adr)], got);
    end
  endtask

  task automatic dataCacheAccesses();
    logic [31:0] adr;
    logic [31:0] got;
    logic        st;
    cpWrite(4'd1, 4'd0, 32'h1 << memSysPkg::CTRL_D_BIT);
    cpRead(4'd1, got);
    checkWord("ctrlDataEnable", 32'h1 << memSysPkg::CTRL_D_BIT, got);
    for (int i = 0; i < NumData; i++) begin
      adr = randomWordAddr(DataBase, DataWords);
      if (($urandom % 3) == 0) begin
        storeWord(adr, $urandom, 4'($urandom));
      end else begin
        loadWord(adr, got, st);
        checkWord("cachedLoad", model[wordIndex(adr)], got);
        // Line now resident so no stall
        loadWord(adr, got, st);
        checkWord("residentLoadStall", 32'h0, 32'(st));
        checkWord("residentLoad", model[wordIndex(adr)], got);
      end
    end
  endtask

  task automatic instrCacheAccesses();
    logic [31:0] pc;
    logic [31:0] exp;
    logic [31:0] got;
    logic        st;
    cpWrite(4'd1, 4'd0, (32'h1 << memSysPkg::CTRL_I_BIT) | (32'h1 << memSysPkg::CTRL_D_BIT));
    cpRead(4'd1, got);
    checkWord("ctrlBothEnable",
              (32'h1 << memSysPkg::CTRL_I_BIT) | (32'h1 << memSysPkg::CTRL_D_BIT), got);
    for (int i = 0; i < NumCode; i++) begin
      pc = randomWordAddr(CodeBase, CodeWords);
      mirrorLookup(pc, exp);
      doFetch(pc, got, st);
      checkWord("cachedFetch", exp, got);
    end
    // Self-modifying code is not seen by the icache
    stalePc = randomWordAddr(CodeBase, CodeWords);
    mirrorLookup(stalePc, exp);
    doFetch(stalePc, got, st);
    checkWord("codeBeforeStore", exp, got);
    storeWord(stalePc, ~model[wordIndex(stalePc)], 4'hF);
    mirrorLookup(stalePc, exp);
    doFetch(stalePc, got, st);
    checkWord("staleFetchStall", 32'h0, 32'(st));
    checkWord("staleFetch", exp, got);
  endtask

  task automatic invalidateCaches();
    logic [31:0] adr;
    logic [31:0] exp;
    logic [31:0] got;
    logic        st;
    cpWrite(4'd7, 4'd5, 32'h0);
    mirValid = '0;
    mirrorLookup(stalePc, exp);
    doFetch(stalePc, got, st);
    checkWord("invalidatedFetchStall", 32'h1, 32'(st));
    checkWord("invalidatedFetch", exp, got);
    // Make a data line resident and then drop it
    adr = randomWordAddr(DataBase, DataWords);
    loadWord(adr, got, st);
    loadWord(adr, got, st);
    checkWord("residentBeforeInvalidate", 32'h0, 32'(st));
    cpWrite(4'd7, 4'd6, 32'h0);
    loadWord(adr, got, st);
    checkWord("invalidatedLoadStall", 32'h1, 32'(st));
    checkWord("invalidatedLoad", model[wordIndex(adr)], got);
  endtask

  // Both ports busy at once with the arbiter picking the order
  task automatic concurrentAccesses();
    for (int i = 0; i < NumMixed; i++) begin
      mixPc[i]  = randomWordAddr(CodeBase, MixWords);
      mixAdr[i] = randomWordAddr(CodeBase, MixWords);
    end
    fork
      begin
        logic [31:0] exp;
        logic [31:0] got;
        logic        st;
        for (int i = 0; i < NumMixed; i++) begin
          mirrorLookup(mixPc[i], exp);
          doFetch(mixPc[i], got, st);
          checkWord("mixedFetch", exp, got);
        end
      end
      begin
        logic [31:0] got;
        logic        st;
        for (int i = 0; i < NumMixed; i++) begin
          loadWord(mixAdr[i], got, st);
          checkWord("mixedLoad", model[wordIndex(mixAdr[i])], got);
        end
      end
    join
  endtask

  task automatic readIdRegister();
    logic [31:0] got;
    cpRead(4'd0, got);
    checkWord("idRegister", memSysPkg::CP_ID_VALUE, got);
  endtask

  initial begin
    void'($urandom(40));
    rst      = 1'b1;
    fetch    = '0;
    data     = '0;
    cp       = '0;
    mirValid = '0;
    for (int i = 0; i < MemWords; i++) begin
      model[i] = 32'h0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    uncachedAccesses();
    dataCacheAccesses();
    instrCacheAccesses();
    invalidateCaches();
    concurrentAccesses();
    readIdRegister();
    if (errorCount == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire
